// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_dec_tb
FLIST     ?= selen_dec.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(wildcard design/*.sv design/*.svh verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/core_cpu_ctrl.sv ====
// --------------------------------------------------------------------------
// rv32i control decoder
// instruction word to execute controls and sign-extended immediate
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_cpu_ctrl (
	input  logic [`SELEN_XLEN-1:0] inst,
	output selen_dec_pkg::ctrl_t   ctrl,
	output logic [`SELEN_XLEN-1:0] imm
);
	import selen_dec_pkg::*;

	logic [2:0]             f3;
	logic [6:0]             f7;
	logic                   ok;
	logic [`SELEN_XLEN-1:0] imm_i;
	logic [`SELEN_XLEN-1:0] imm_s;
	logic [`SELEN_XLEN-1:0] imm_b;
	logic [`SELEN_XLEN-1:0] imm_u;
	logic [`SELEN_XLEN-1:0] imm_j;

	// shared by OP and OP_IMM, alt picks sub/sra
	function automatic alu_op_e arith_op(input logic [2:0] fn3, input logic alt);
		case (fn3)
			3'd0:    return alt ? ALU_SUB : ALU_ADD;
			3'd1:    return ALU_SLL;
			3'd2:    return ALU_SLT;
			3'd3:    return ALU_SLTU;
			3'd4:    return ALU_XOR;
			3'd5:    return alt ? ALU_SRA : ALU_SRL;
			3'd6:    return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign f3 = inst[14:12];
	assign f7 = inst[31:25];

	// immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		imm = '0;
		ok = 1'b1;
		case (opcode_e'(inst[6:0]))
			OPC_LUI: begin
				ctrl.alu_op = ALU_PASS_B;
				ctrl.mux_bus = MUX_B_IMM;
				ctrl.we_reg = 1'b1;
				imm = imm_u;
			end
			OPC_AUIPC: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.mux_bus = MUX_A_PC | MUX_B_IMM;
				ctrl.we_reg = 1'b1;
				imm = imm_u;
			end
			OPC_JAL: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.mux_bus = MUX_A_PC | MUX_B_IMM | MUX_RES_PC4 | MUX_JUMP;
				ctrl.we_reg = 1'b1;
				imm = imm_j;
			end
			OPC_JALR: begin
				ok = (f3 == 3'd0);
				ctrl.alu_op = ALU_ADD;
				ctrl.mux_bus = MUX_B_IMM | MUX_RES_PC4 | MUX_JUMP;
				ctrl.we_reg = 1'b1;
				ctrl.haz_cmd = HAZ_USE_RS1;
				imm = imm_i;
			end
			OPC_BRANCH: begin
				// funct3 2 and 3 are unused
				ok = (f3[2:1] != 2'b01);
				ctrl.alu_cnd = f3;
				ctrl.alu_op = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
				ctrl.mux_bus = MUX_BRANCH;
				ctrl.haz_cmd = HAZ_USE_BOTH;
				imm = imm_b;
			end
			OPC_LOAD: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.mux_bus = MUX_B_IMM | MUX_RES_MEM;
				ctrl.we_reg = 1'b1;
				ctrl.l1d_val = 1'b1;
				ctrl.haz_cmd = HAZ_USE_RS1;
				imm = imm_i;
				case (f3)
					3'd0: {ctrl.l1d_size, ctrl.wb_sx_op} = {SIZE_BYTE, SX_SB};
					3'd1: {ctrl.l1d_size, ctrl.wb_sx_op} = {SIZE_HALF, SX_SH};
					3'd2: {ctrl.l1d_size, ctrl.wb_sx_op} = {SIZE_WORD, SX_SW};
					3'd4: {ctrl.l1d_size, ctrl.wb_sx_op} = {SIZE_BYTE, SX_UB};
					3'd5: {ctrl.l1d_size, ctrl.wb_sx_op} = {SIZE_HALF, SX_UH};
					default: ok = 1'b0;
				endcase
			end
			OPC_STORE: begin
				ok = (f3 < 3'd3);
				ctrl.alu_op = ALU_ADD;
				ctrl.mux_bus = MUX_B_IMM;
				ctrl.l1d_val = 1'b1;
				ctrl.l1d_cop = 1'b1;
				ctrl.l1d_size = (f3 == 3'd0) ? SIZE_BYTE : (f3 == 3'd1) ? SIZE_HALF : SIZE_WORD;
				ctrl.haz_cmd = HAZ_USE_BOTH;
				imm = imm_s;
			end
			OPC_OP_IMM: begin
				// shift immediates carry funct7 in the upper bits
				if (f3 == 3'd1)
					ok = (f7 == 7'b0000000);
				else if (f3 == 3'd5)
					ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
				ctrl.alu_op = arith_op(f3, f7[5] && f3 == 3'd5);
				ctrl.mux_bus = MUX_B_IMM;
				ctrl.we_reg = 1'b1;
				ctrl.haz_cmd = HAZ_USE_RS1;
				imm = imm_i;
			end
			OPC_OP: begin
				ok = (f7 == 7'b0000000) ||
					(f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5));
				ctrl.alu_op = arith_op(f3, f7[5]);
				ctrl.we_reg = 1'b1;
				ctrl.haz_cmd = HAZ_USE_BOTH;
			end
			default: ok = 1'b0;
		endcase

		if (ok) begin
			ctrl.inst_val = 1'b1;
		end else begin
			ctrl = '0;
			imm = '0;
		end
	end

endmodule

`default_nettype wire

// ==== design/core_dec_s.sv ====
// --------------------------------------------------------------------------
// decode stage
// register file and control decoder side by side, one output register
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_dec_s (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    hold,
	input  logic                    kill,
	input  selen_dec_pkg::fetch_t   fetch,
	input  selen_dec_pkg::reg_wr_t  wr,
	output selen_dec_pkg::dec_out_t dec_out,
	output logic                    out_valid
);
	import selen_dec_pkg::*;

	ctrl_t                  ctrl;
	logic [`SELEN_XLEN-1:0] imm;
	logic [`SELEN_XLEN-1:0] src1;
	logic [`SELEN_XLEN-1:0] src2;
	logic                   take;

	ctrl_t                  ctrl_q;
	logic [4:0]             rs1_q;
	logic [4:0]             rs2_q;
	logic [4:0]             rd_q;
	logic [`SELEN_XLEN-1:0] src1_q;
	logic [`SELEN_XLEN-1:0] src2_q;
	logic [`SELEN_XLEN-1:0] imm_q;
	logic [`SELEN_XLEN-1:0] pc_q;
	logic [`SELEN_XLEN-1:0] pc_4_q;

	core_reg_file core_reg_file_inst (
		.clk  (clk),
		.rst_n(rst_n),
		.rs1  (fetch.inst[19:15]),
		.rs2  (fetch.inst[24:20]),
		.wr   (wr),
		.src1 (src1),
		.src2 (src2)
	);

	core_cpu_ctrl core_cpu_ctrl_inst (
		.inst(fetch.inst),
		.ctrl(ctrl),
		.imm (imm)
	);

	assign take = fetch.valid && !hold;

	// --------------------------------------------------------------------------
	// stage register, kill wins over enable
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || kill) begin
			ctrl_q <= '0;
			rs1_q <= '0;
			rs2_q <= '0;
			rd_q <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= take;
			if (take) begin
				ctrl_q <= ctrl;
				rs1_q <= fetch.inst[19:15];
				rs2_q <= fetch.inst[24:20];
				rd_q <= fetch.inst[11:7];
			end
		end
	end

	// operands and addresses
	always_ff @(posedge clk) begin
		if (take) begin
			src1_q <= src1;
			src2_q <= src2;
			imm_q <= imm;
			pc_q <= fetch.pc;
			pc_4_q <= fetch.pc_4;
		end
	end

	assign dec_out = '{ctrl: ctrl_q, src1: src1_q, src2: src2_q, imm: imm_q,
		pc: pc_q, pc_4: pc_4_q, rs1: rs1_q, rs2: rs2_q, rd: rd_q};

endmodule

`default_nettype wire

// ==== design/core_dec_top.sv ====
// --------------------------------------------------------------------------
// fetch and decode front end top level
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_dec_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    hold,
	input  logic                    kill,
	// instruction memory
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [`SELEN_WB_AW-1:0] wb_adr,
	input  logic [`SELEN_XLEN-1:0]  wb_dat_i,
	input  logic                    wb_ack,
	// writeback into the register file
	input  selen_dec_pkg::reg_wr_t  wr,
	output selen_dec_pkg::dec_out_t dec_out,
	output logic                    out_valid
);
	import selen_dec_pkg::*;

	fetch_t fetch;

	core_if_fetch core_if_fetch_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.hold    (hold),
		.wb_cyc  (wb_cyc),
		.wb_stb  (wb_stb),
		.wb_we   (wb_we),
		.wb_adr  (wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack  (wb_ack),
		.fetch   (fetch)
	);

	core_dec_s core_dec_s_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.kill     (kill),
		.fetch    (fetch),
		.wr       (wr),
		.dec_out  (dec_out),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

// ==== design/core_if_fetch.sv ====
// --------------------------------------------------------------------------
// instruction fetch, wishbone classic master
// one read in flight, word held under hold, pc steps by four
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_if_fetch (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    hold,
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [`SELEN_WB_AW-1:0] wb_adr,
	input  logic [`SELEN_XLEN-1:0]  wb_dat_i,
	input  logic                    wb_ack,
	output selen_dec_pkg::fetch_t   fetch
);

	// IDLE after reset, REQ drives the bus, HAND offers the word to decode
	typedef enum logic [1:0] {IDLE, REQ, HAND} state_e;

	state_e                 state;
	logic [`SELEN_XLEN-1:0] pc;
	logic [`SELEN_XLEN-1:0] pc_4;
	logic [`SELEN_XLEN-1:0] inst_q;

	assign pc_4 = pc + `SELEN_XLEN'(4);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			pc <= `SELEN_RESET_PC;
		end else begin
			case (state)
				IDLE: if (!hold) state <= REQ;
				REQ:  if (wb_ack) state <= HAND;
				HAND: begin
					// decode takes the word on this edge
					if (!hold) begin
						state <= REQ;
						pc <= pc_4;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == REQ && wb_ack)
			inst_q <= wb_dat_i;
	end

	// --------------------------------------------------------------------------
	// bus and decode side outputs
	// --------------------------------------------------------------------------
	assign wb_cyc = (state == REQ);
	assign wb_stb = (state == REQ);
	assign wb_we = 1'b0;
	assign wb_adr = pc[`SELEN_WB_AW-1:0];

	assign fetch = '{valid: (state == HAND), inst: inst_q, pc: pc, pc_4: pc_4};

endmodule

`default_nettype wire

// ==== design/core_reg_file.sv ====
// --------------------------------------------------------------------------
// integer register file, two async read ports, one write port
// x0 hard zero, same-cycle write forwarded to reads
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [4:0]             rs1,
	input  logic [4:0]             rs2,
	input  selen_dec_pkg::reg_wr_t wr,
	output logic [`SELEN_XLEN-1:0] src1,
	output logic [`SELEN_XLEN-1:0] src2
);

	logic [`SELEN_XLEN-1:0] regs [`SELEN_NREGS];

	// x0 first, then the bypass, then the array
	function automatic logic [`SELEN_XLEN-1:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		if (wr.we && wr.rd == addr)
			return wr.data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `SELEN_NREGS; i++)
				regs[i] <= '0;
		end else if (wr.we && wr.rd != 5'd0) begin
			regs[wr.rd] <= wr.data;
		end
	end

	assign src1 = read_port(rs1);
	assign src2 = read_port(rs2);

endmodule

`default_nettype wire

// ==== design/selen_dec_pkg.sv ====
// --------------------------------------------------------------------------
// shared types of the decode front end
// opcode and operation enums, control and bundle structs
// --------------------------------------------------------------------------
`default_nettype none
`include "selen_dec_settings.svh"

package selen_dec_pkg;

	// rv32i major opcodes, compressed and system left out
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	// load result extension, signed b/h/w and unsigned b/h
	typedef enum logic [2:0] {
		SX_NONE, SX_SB, SX_SH, SX_SW, SX_UB, SX_UH
	} wb_sx_op_e;

	typedef enum logic [2:0] {
		SIZE_BYTE = 3'b001,
		SIZE_HALF = 3'b010,
		SIZE_WORD = 3'b100
	} l1d_size_e;

	typedef enum logic [1:0] {
		HAZ_NONE, HAZ_USE_RS1, HAZ_USE_BOTH
	} haz_cmd_e;

	// mux_bus bits
	localparam logic [5:0] MUX_A_PC    = 6'b000001;  // operand a is pc, else src1
	localparam logic [5:0] MUX_B_IMM   = 6'b000010;  // operand b is imm, else src2
	localparam logic [5:0] MUX_RES_PC4 = 6'b000100;  // link value pc+4 to rd
	localparam logic [5:0] MUX_RES_MEM = 6'b001000;  // rd from load data
	localparam logic [5:0] MUX_BRANCH  = 6'b010000;
	localparam logic [5:0] MUX_JUMP    = 6'b100000;

	typedef struct packed {
		alu_op_e    alu_op;
		logic [2:0] alu_cnd;
		logic [5:0] mux_bus;
		logic       we_reg;
		logic       l1d_val;
		logic       l1d_cop;
		l1d_size_e  l1d_size;
		wb_sx_op_e  wb_sx_op;
		haz_cmd_e   haz_cmd;
		logic       inst_val;
	} ctrl_t;

	typedef struct packed {
		logic                   we;
		logic [4:0]             rd;
		logic [`SELEN_XLEN-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		logic [`SELEN_XLEN-1:0] src1;
		logic [`SELEN_XLEN-1:0] src2;
		logic [`SELEN_XLEN-1:0] imm;
		logic [`SELEN_XLEN-1:0] pc;
		logic [`SELEN_XLEN-1:0] pc_4;
		logic [4:0]             rs1;
		logic [4:0]             rs2;
		logic [4:0]             rd;
	} dec_out_t;

	typedef struct packed {
		logic                   valid;
		logic [`SELEN_XLEN-1:0] inst;
		logic [`SELEN_XLEN-1:0] pc;
		logic [`SELEN_XLEN-1:0] pc_4;
	} fetch_t;

endpackage

`default_nettype wire

// ==== design/selen_dec_settings.svh ====
// --------------------------------------------------------------------------
// global sizes for the rv32i fetch and decode front end
// data width, register count, reset pc, wishbone address width
// --------------------------------------------------------------------------
`ifndef SELEN_DEC_SETTINGS_SVH
`define SELEN_DEC_SETTINGS_SVH

// instruction and data word width
`define SELEN_XLEN      32
`define SELEN_NREGS     32
// first fetch address after reset
`define SELEN_RESET_PC  32'h0000_0100
`define SELEN_WB_AW     32

`endif

// ==== selen_dec.f ====
+incdir+design
design/selen_dec_pkg.sv
design/core_reg_file.sv
design/core_cpu_ctrl.sv
design/core_if_fetch.sv
design/core_dec_s.sv
design/core_dec_top.sv
verif/core_dec_checker.sv
verif/core_dec_asserts.sv
verif/core_dec_tb.sv

// ==== verif/core_dec_asserts.sv ====
// --------------------------------------------------------------------------
// concurrent assertions on the wishbone port and out_valid
// bound into the front end top level
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_dec_asserts (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    kill,
	input logic                    wb_cyc,
	input logic                    wb_stb,
	input logic [`SELEN_WB_AW-1:0] wb_adr,
	input logic                    wb_ack,
	input logic                    out_valid
);

	// request stays inside its bus cycle until the slave answers
	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && wb_cyc)
		else $error("wishbone request dropped before ack");

	// address held until the slave answers
	adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr))
		else $error("wishbone address changed while waiting for ack");

	no_valid_after_kill: assert property (@(posedge clk) disable iff (!rst_n)
		kill |=> !out_valid)
		else $error("out_valid high right after a kill edge");

endmodule

bind core_dec_top core_dec_asserts core_dec_asserts_inst (.*);

`default_nettype wire

// ==== verif/core_dec_checker.sv ====
// --------------------------------------------------------------------------
// reference model of the decoder, register file and fetch order
// compares every decoded bundle and counts errors
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_dec_checker (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    hold,
	input  logic                    kill,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`SELEN_WB_AW-1:0] wb_adr,
	input  logic [`SELEN_XLEN-1:0]  wb_dat_i,
	input  logic                    wb_ack,
	input  selen_dec_pkg::reg_wr_t  wr,
	input  selen_dec_pkg::dec_out_t dec_out,
	input  logic                    out_valid,
	output int                      errors,
	output int                      checks,
	output int                      bundles,
	output int                      kills,
	output int                      acks
);
	import selen_dec_pkg::*;

	logic [31:0] regs [32];
	logic [31:0] pc_m;
	logic [31:0] word;
	logic        word_held;
	logic        exp_valid;
	dec_out_t    exp;
	ctrl_t       c_m;
	logic [31:0] imm_m;

	initial begin
		errors = 0;
		checks = 0;
		bundles = 0;
		kills = 0;
		acks = 0;
	end

	function automatic l1d_size_e size_of(input logic [1:0] sz);
		return (sz == 2'd0) ? SIZE_BYTE : (sz == 2'd1) ? SIZE_HALF : SIZE_WORD;
	endfunction

	function automatic logic [31:0] read_reg(input logic [4:0] a);
		if (a == 5'd0)
			return 32'd0;
		if (wr.we && wr.rd == a)
			return wr.data;
		return regs[a];
	endfunction

	// decoder model
	function automatic void model_decode(input logic [31:0] w, output ctrl_t c,
		output logic [31:0] im);
		logic [2:0] f3;
		logic [6:0] f7;
		logic       ok;
		alu_op_e    tbl [8];
		tbl = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
		f3 = w[14:12];
		f7 = w[31:25];
		c = '0;
		im = '0;
		ok = 1'b0;
		case (w[6:0])
			OPC_LUI: begin
				ok = 1'b1;
				c.alu_op = ALU_PASS_B;
				c.mux_bus = MUX_B_IMM;
				c.we_reg = 1'b1;
				im = {w[31:12], 12'h000};
			end
			OPC_AUIPC: begin
				ok = 1'b1;
				c.alu_op = ALU_ADD;
				c.mux_bus = MUX_A_PC | MUX_B_IMM;
				c.we_reg = 1'b1;
				im = {w[31:12], 12'h000};
			end
			OPC_JAL: begin
				ok = 1'b1;
				c.alu_op = ALU_ADD;
				c.mux_bus = MUX_A_PC | MUX_B_IMM | MUX_RES_PC4 | MUX_JUMP;
				c.we_reg = 1'b1;
				im = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			OPC_JALR: begin
				ok = (f3 == 3'd0);
				c.alu_op = ALU_ADD;
				c.mux_bus = MUX_B_IMM | MUX_RES_PC4 | MUX_JUMP;
				c.we_reg = 1'b1;
				c.haz_cmd = HAZ_USE_RS1;
				im = {{20{w[31]}}, w[31:20]};
			end
			OPC_BRANCH: begin
				ok = (f3 != 3'd2) && (f3 != 3'd3);
				c.alu_op = (f3 < 3'd4) ? ALU_SUB : (f3 < 3'd6) ? ALU_SLT : ALU_SLTU;
				c.alu_cnd = f3;
				c.mux_bus = MUX_BRANCH;
				c.haz_cmd = HAZ_USE_BOTH;
				im = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			OPC_LOAD: begin
				ok = (f3 != 3'd3) && (f3 < 3'd6);
				c.alu_op = ALU_ADD;
				c.mux_bus = MUX_B_IMM | MUX_RES_MEM;
				c.we_reg = 1'b1;
				c.l1d_val = 1'b1;
				c.l1d_size = size_of(f3[1:0]);
				c.wb_sx_op = f3[2] ? (f3[0] ? SX_UH : SX_UB) :
					(f3[1] ? SX_SW : (f3[0] ? SX_SH : SX_SB));
				c.haz_cmd = HAZ_USE_RS1;
				im = {{20{w[31]}}, w[31:20]};
			end
			OPC_STORE: begin
				ok = (f3 <= 3'd2);
				c.alu_op = ALU_ADD;
				c.mux_bus = MUX_B_IMM;
				c.l1d_val = 1'b1;
				c.l1d_cop = 1'b1;
				c.l1d_size = size_of(f3[1:0]);
				c.haz_cmd = HAZ_USE_BOTH;
				im = {{20{w[31]}}, w[31:25], w[11:7]};
			end
			OPC_OP_IMM: begin
				ok = (f3 == 3'd1) ? (f7 == 7'h00) :
					(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
				c.alu_op = (f3 == 3'd5 && f7[5]) ? ALU_SRA : tbl[f3];
				c.mux_bus = MUX_B_IMM;
				c.we_reg = 1'b1;
				c.haz_cmd = HAZ_USE_RS1;
				im = {{20{w[31]}}, w[31:20]};
			end
			OPC_OP: begin
				ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				c.alu_op = tbl[f3];
				if (f7[5] && f3 == 3'd0)
					c.alu_op = ALU_SUB;
				if (f7[5] && f3 == 3'd5)
					c.alu_op = ALU_SRA;
				c.we_reg = 1'b1;
				c.haz_cmd = HAZ_USE_BOTH;
			end
			default: ok = 1'b0;
		endcase
		if (ok) begin
			c.inst_val = 1'b1;
		end else begin
			c = '0;
			im = '0;
		end
	endfunction

	task automatic check_field(input string name, input logic [63:0] expv,
		input logic [63:0] actv);
		checks = checks + 1;
		if (expv !== actv) begin
			$display("FAILED %s at pc %h: expected %h, actual %h", name, exp.pc, expv, actv);
			errors = errors + 1;
		end
	endtask

	// --------------------------------------------------------------------------
	// per-edge model on the pre-edge values of the DUT flops
	// --------------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] = '0;
			pc_m = `SELEN_RESET_PC;
			word_held = 1'b0;
			exp_valid = 1'b0;
		end else begin
			if (exp_valid && !out_valid) begin
				$display("decoded bundle for pc %h never showed out_valid", exp.pc);
				errors = errors + 1;
			end
			if (out_valid && !exp_valid) begin
				$display("out_valid high with no instruction accepted by decode");
				errors = errors + 1;
			end
			if (out_valid && exp_valid) begin
				bundles = bundles + 1;
				check_field("ctrl", 64'(exp.ctrl), 64'(dec_out.ctrl));
				check_field("imm", 64'(exp.imm), 64'(dec_out.imm));
				check_field("src1", 64'(exp.src1), 64'(dec_out.src1));
				check_field("src2", 64'(exp.src2), 64'(dec_out.src2));
				check_field("pc", 64'(exp.pc), 64'(dec_out.pc));
				check_field("pc_4", 64'(exp.pc_4), 64'(dec_out.pc_4));
				check_field("rs1", 64'(exp.rs1), 64'(dec_out.rs1));
				check_field("rs2", 64'(exp.rs2), 64'(dec_out.rs2));
				check_field("rd", 64'(exp.rd), 64'(dec_out.rd));
			end
			exp_valid = 1'b0;

			// decode takes the held word
			if (word_held && !hold) begin
				if (kill) begin
					kills = kills + 1;
				end else begin
					model_decode(word, c_m, imm_m);
					exp = '{ctrl: c_m, src1: read_reg(word[19:15]),
						src2: read_reg(word[24:20]), imm: imm_m, pc: pc_m,
						pc_4: pc_m + 32'd4, rs1: word[19:15], rs2: word[24:20],
						rd: word[11:7]};
					exp_valid = 1'b1;
				end
				pc_m = pc_m + 32'd4;
				word_held = 1'b0;
			end

			if (wb_cyc && wb_stb && wb_ack) begin
				acks = acks + 1;
				checks = checks + 1;
				if (wb_adr !== pc_m) begin
					$display("FAILED wb_adr: expected %h, actual %h", pc_m, wb_adr);
					errors = errors + 1;
				end
				checks = checks + 1;
				if (wb_we !== 1'b0) begin
					$display("FAILED wb_we: expected 0, actual %b", wb_we);
					errors = errors + 1;
				end
				word = wb_dat_i;
				word_held = 1'b1;
			end

			if (wr.we && wr.rd != 5'd0)
				regs[wr.rd] = wr.data;
		end
	end

endmodule

`default_nettype wire

// ==== verif/core_dec_tb.sv ====
// --------------------------------------------------------------------------
// testbench top for the fetch and decode front end
// clock, reset, wishbone memory responder, random stimulus, watchdog
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "selen_dec_settings.svh"

module core_dec_tb;
	import selen_dec_pkg::*;

	localparam int NUM_INSTR = 400;
	localparam int CLK_NS = 4;
	localparam int TIMEOUT_NS = NUM_INSTR * 8 * CLK_NS + 8 * CLK_NS;

	logic                    clk;
	logic                    rst_n;
	logic                    hold;
	logic                    kill;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [`SELEN_WB_AW-1:0] wb_adr;
	logic [`SELEN_XLEN-1:0]  wb_dat_i;
	logic                    wb_ack;
	reg_wr_t                 wr;
	dec_out_t                dec_out;
	logic                    out_valid;

	int          errors;
	int          checks;
	int          bundles;
	int          kills;
	int          acks;
	int          seed;
	int          ack_wait;
	int          count_errors;
	logic        verdict_done;
	logic [31:0] imem [NUM_INSTR];
	logic [31:0] r;
	logic [31:0] r2;
	logic [31:0] idx;

	core_dec_top core_dec_top_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.kill     (kill),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_ack   (wb_ack),
		.wr       (wr),
		.dec_out  (dec_out),
		.out_valid(out_valid)
	);

	core_dec_checker core_dec_checker_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.kill     (kill),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_ack   (wb_ack),
		.wr       (wr),
		.dec_out  (dec_out),
		.out_valid(out_valid),
		.errors   (errors),
		.checks   (checks),
		.bundles  (bundles),
		.kills    (kills),
		.acks     (acks)
	);

	// one instruction word with its class from s and free fields from r
	function automatic logic [31:0] make_inst(input logic [31:0] r_in, input logic [31:0] s);
		logic [31:0] w;
		logic [2:0]  f3;
		w = r_in;
		f3 = r_in[14:12];
		case (s[11:8] % 4'd9)
			4'd0: begin
				w[31:25] = (s[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
				w[6:0] = OPC_OP;
			end
			4'd1: begin
				if (f3 == 3'd1)
					w[31:25] = 7'h00;
				if (f3 == 3'd5)
					w[31:25] = s[12] ? 7'h20 : 7'h00;
				w[6:0] = OPC_OP_IMM;
			end
			4'd2: begin
				case (s[15:13])
					3'd0, 3'd5: w[14:12] = 3'd0;
					3'd1:       w[14:12] = 3'd1;
					3'd2, 3'd6: w[14:12] = 3'd2;
					3'd3, 3'd7: w[14:12] = 3'd4;
					default:    w[14:12] = 3'd5;
				endcase
				w[6:0] = OPC_LOAD;
			end
			4'd3: begin
				w[14:12] = (s[14:13] == 2'd3) ? 3'd2 : {1'b0, s[14:13]};
				w[6:0] = OPC_STORE;
			end
			4'd4: begin
				// funct3 2 and 3 moved to 6 and 7
				if (f3[2:1] == 2'b01)
					w[14] = 1'b1;
				w[6:0] = OPC_BRANCH;
			end
			4'd5: w[6:0] = OPC_LUI;
			4'd6: w[6:0] = OPC_AUIPC;
			4'd7: w[6:0] = OPC_JAL;
			default: begin
				w[14:12] = 3'd0;
				w[6:0] = OPC_JALR;
			end
		endcase
		// about one in eight words made illegal by a system or compressed opcode
		if (s[18:16] == 3'd0)
			w[6:0] = s[19] ? 7'b1110011 : {r_in[6:2], 2'b00};
		return w;
	endfunction

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// --------------------------------------------------------------------------
	// falling edge stimulus and wishbone responder
	// --------------------------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			r = $random(seed);
			r2 = $random(seed);
			hold = (r[13:12] == 2'd0);
			kill = (r[10:8] == 3'd0) && r[11];
			wr = '{we: r[0], rd: r[5:1], data: r2};
			if (wb_ack) begin
				wb_ack = 1'b0;
				ack_wait = int'(r[17:16]);
			end else if (wb_cyc && wb_stb) begin
				idx = (wb_adr - `SELEN_RESET_PC) >> 2;
				if (idx < NUM_INSTR) begin
					if (ack_wait == 0) begin
						wb_ack = 1'b1;
						wb_dat_i = imem[idx[8:0]];
					end else begin
						ack_wait = ack_wait - 1;
					end
				end
			end
		end
	end

	initial begin
		seed = 1;
		count_errors = 0;
		verdict_done = 1'b0;
		rst_n = 1'b0;
		hold = 1'b0;
		kill = 1'b0;
		wb_dat_i = '0;
		wb_ack = 1'b0;
		wr = '0;
		ack_wait = 0;
		for (int i = 0; i < NUM_INSTR; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			imem[i] = make_inst(r, r2);
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		wait (bundles + kills >= NUM_INSTR);
		repeat (4) @(negedge clk);
		if (acks != bundles + kills) begin
			$display("acks and results differ: %0d acks, %0d bundles plus %0d kills",
				acks, bundles, kills);
			count_errors = count_errors + 1;
		end
		$display("errors %0d, checks %0d, bundles %0d, kills %0d, acks %0d",
			errors + count_errors, checks, bundles, kills, acks);
		verdict_done = 1'b1;
		if (errors + count_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: only %0d of %0d instructions finished decode",
			bundles + kills, NUM_INSTR);
		verdict_done = 1'b1;
		$display("FAIL: see errors above");
		$finish;
	end

	// run ended before the closing verdict
	final begin
		if (!verdict_done)
			$display("FAIL: see errors above");
	end

endmodule

`default_nettype wire
